//--- verilog/csr_pkg.sv
// widths, csr map and op encoding; unknown addresses read zero and ignore writes
package csr_pkg;

    // datapath and tag widths
    localparam int XLEN        = 32;
    localparam int CSR_ADDR_W  = 12;
    localparam int REG_ADDR_W  = 5;   // integer register index
    localparam int COMMIT_ID_W = 4;
    localparam int FP_PEND_W   = 3;   // up to 7 fp ops outstanding

    // fp csr field widths
    localparam int FFLAGS_W = 5;      // nv dz of uf nx
    localparam int FRM_W    = 3;      // rounding mode

    // csr operation, immediate forms are resolved before this point
    typedef enum logic [1:0] {
        OP_NONE = 2'b00,
        OP_RW   = 2'b01,
        OP_RS   = 2'b10,
        OP_RC   = 2'b11
    } csr_op_e;

    // fp csrs, user level
    localparam logic [CSR_ADDR_W-1:0] CSR_FFLAGS   = 12'h001;
    localparam logic [CSR_ADDR_W-1:0] CSR_FRM      = 12'h002;
    localparam logic [CSR_ADDR_W-1:0] CSR_FCSR     = 12'h003;

    // machine mode csrs
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

    // writable bits of the fp fields
    localparam logic [XLEN-1:0] FFLAGS_MASK = 32'h0000_001f;
    localparam logic [XLEN-1:0] FRM_MASK    = 32'h0000_0007;

    // alignment, low two bits read as zero
    localparam logic [XLEN-1:0] MTVEC_MASK  = 32'hffff_fffc; // direct mode only
    localparam logic [XLEN-1:0] MEPC_MASK   = 32'hffff_fffc; // no compressed support

endpackage

//--- verilog/csr_alu.sv
// new csr value from op, operand and old value; rs and rc with zero operand do not write
`timescale 1ns/10ps

module csr_alu import csr_pkg::*; (
    input  csr_op_e         csr_op_i,
    input  logic [XLEN-1:0] csr_op1_i,     // rs1 value, already resolved
    input  logic [XLEN-1:0] csr_rdata_i,   // current csr contents

    output logic [XLEN-1:0] csr_wdata_o,
    output logic            wen_req_o
);

    logic op1_nz;   // operand has any bit set

    assign op1_nz = |csr_op1_i;

    // new value
    always_comb begin
        case (csr_op_i)
            OP_RW:   csr_wdata_o = csr_op1_i;
            OP_RS:   csr_wdata_o = csr_rdata_i | csr_op1_i;     // set bits
            OP_RC:   csr_wdata_o = csr_rdata_i & ~csr_op1_i;    // clear bits
            default: csr_wdata_o = csr_rdata_i;                 // no change
        endcase
    end

    // architectural write rule
    always_comb begin
        case (csr_op_i)
            OP_RW:   wen_req_o = 1'b1;     // rw always writes
            OP_RS,
            OP_RC:   wen_req_o = op1_nz;   // x0 source leaves csr alone
            default: wen_req_o = 1'b0;
        endcase
    end

endmodule

//--- verilog/csr_ctrl.sv
// combinational accept and stall logic, clk and reset unused; hold request fields while stalled
`timescale 1ns/10ps

module csr_ctrl import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // request side
    input  logic                  req_csr_i,      // level, held while stalled
    input  logic                  int_assert_i,   // squashes the request this cycle
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  logic                  reg_we_i,       // request wants integer writeback

    // status from datapath
    input  logic                  wen_req_i,      // alu says the op really writes
    input  logic                  buf_full_i,
    input  logic                  wb_ready_i,
    input  logic                  fp_pending_i,

    // strobes
    output logic                  accept_o,
    output logic                  csr_we_o,
    output logic                  buf_load_o,
    output logic                  csr_stall_o
);

    logic fp_csr_hit;   // fflags or fcsr addressed
    logic req_live;     // request not killed by interrupt
    logic buf_hazard;
    logic fp_hazard;

    // fflags and fcsr both see the accumulated flags
    assign fp_csr_hit = (csr_addr_i == CSR_FFLAGS) || (csr_addr_i == CSR_FCSR);

    assign req_live   = req_csr_i & ~int_assert_i;

    // buffer still occupied and nobody draining it
    assign buf_hazard = buf_full_i & ~wb_ready_i;

    // flags not final while fp ops are in flight
    assign fp_hazard  = fp_csr_hit & fp_pending_i;

    // squashed requests never raise the stall
    assign csr_stall_o = req_live & (buf_hazard | fp_hazard);

    // a held request after a squash goes again as soon as the interrupt drops
    assign accept_o   = req_live & ~csr_stall_o;

    // csr file write only for ops that architecturally write
    assign csr_we_o   = accept_o & wen_req_i;

    // result goes to writeback only if rd is written
    assign buf_load_o = accept_o & reg_we_i;

endmodule

//--- verilog/csr_regfile.sv
// machine and fp csrs, all reset to zero; no privilege checks, unknown addresses read zero
`timescale 1ns/10ps

module csr_regfile import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // single read/write port, shared address
    input  logic [CSR_ADDR_W-1:0] raddr_i,
    input  logic                  we_i,
    input  logic [XLEN-1:0]       wdata_i,

    // fp flag accumulation from the tracker
    input  logic                  flag_acc_en_i,
    input  logic [FFLAGS_W-1:0]   flag_acc_i,

    output logic [XLEN-1:0]       rdata_o
);

    // machine csrs
    logic [XLEN-1:0]     mstatus_q;
    logic [XLEN-1:0]     mtvec_q;
    logic [XLEN-1:0]     mepc_q;
    logic [XLEN-1:0]     mcause_q;
    logic [XLEN-1:0]     mscratch_q;

    // fp csrs, fcsr is a view of these two
    logic [FFLAGS_W-1:0] fflags_q;
    logic [FRM_W-1:0]    frm_q;

    // masked write values
    logic [XLEN-1:0]     fflags_wr;
    logic [XLEN-1:0]     frm_wr;
    logic [XLEN-1:0]     fcsr_frm_wr;   // frm field taken out of an fcsr write
    logic [XLEN-1:0]     fcsr_view;

    assign fflags_wr   = wdata_i & FFLAGS_MASK;
    assign frm_wr      = wdata_i & FRM_MASK;
    assign fcsr_frm_wr = (wdata_i >> FFLAGS_W) & FRM_MASK;

    // frm over fflags, upper bits zero
    assign fcsr_view   = {{(XLEN - FRM_W - FFLAGS_W){1'b0}}, frm_q, fflags_q};

    // read mux
    always_comb begin
        case (raddr_i)
            CSR_FFLAGS:   rdata_o = {{(XLEN - FFLAGS_W){1'b0}}, fflags_q};
            CSR_FRM:      rdata_o = {{(XLEN - FRM_W){1'b0}}, frm_q};
            CSR_FCSR:     rdata_o = fcsr_view;
            CSR_MSTATUS:  rdata_o = mstatus_q;
            CSR_MTVEC:    rdata_o = mtvec_q;
            CSR_MEPC:     rdata_o = mepc_q;
            CSR_MCAUSE:   rdata_o = mcause_q;
            CSR_MSCRATCH: rdata_o = mscratch_q;
            default:      rdata_o = '0;   // unimplemented
        endcase
    end

    // writes, software write placed last so it beats a same-edge accumulate
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
            fflags_q   <= '0;
            frm_q      <= '0;
        end else begin
            if (flag_acc_en_i) begin
                fflags_q <= fflags_q | flag_acc_i;   // sticky flags
            end
            if (we_i) begin
                case (raddr_i)
                    CSR_FFLAGS:   fflags_q   <= fflags_wr[FFLAGS_W-1:0];
                    CSR_FRM:      frm_q      <= frm_wr[FRM_W-1:0];
                    CSR_FCSR: begin
                        fflags_q <= fflags_wr[FFLAGS_W-1:0];   // both fields at once
                        frm_q    <= fcsr_frm_wr[FRM_W-1:0];
                    end
                    CSR_MSTATUS:  mstatus_q  <= wdata_i;
                    CSR_MTVEC:    mtvec_q    <= wdata_i & MTVEC_MASK;
                    CSR_MEPC:     mepc_q     <= wdata_i & MEPC_MASK;
                    CSR_MCAUSE:   mcause_q   <= wdata_i;
                    CSR_MSCRATCH: mscratch_q <= wdata_i;
                    default: ;                               // write dropped
                endcase
            end
        end
    end

endmodule

//--- verilog/fp_flag_tracker.sv
// in-flight fp op count and flag fold; at most 7 outstanding, a retire must follow each issue
`timescale 1ns/10ps

module fp_flag_tracker import csr_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,

    // fp pipe events, single cycle pulses
    input  logic                fp_issue_i,
    input  logic                fp_retire_i,
    input  logic [FFLAGS_W-1:0] fp_flags_i,    // valid with fp_retire_i

    output logic                fp_pending_o,
    output logic                flag_acc_en_o,
    output logic [FFLAGS_W-1:0] flag_acc_o
);

    logic [FP_PEND_W-1:0] pend_cnt_q;
    logic                 cnt_full;
    logic                 cnt_empty;

    assign cnt_full  = &pend_cnt_q;   // all ones, 7 in flight
    assign cnt_empty = (pend_cnt_q == '0);

    // up/down count, issue and retire together cancel
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pend_cnt_q <= '0;
        end else begin
            case ({fp_issue_i, fp_retire_i})
                2'b10: begin
                    if (!cnt_full) begin
                        pend_cnt_q <= pend_cnt_q + 1'b1;
                    end
                end
                2'b01: begin
                    if (!cnt_empty) begin
                        pend_cnt_q <= pend_cnt_q - 1'b1;   // no wrap on stray retire
                    end
                end
                default: ;
            endcase
        end
    end

    // high from the cycle after issue to the cycle after the last retire
    assign fp_pending_o  = ~cnt_empty;

    // flags land in fflags at the retire edge
    assign flag_acc_en_o = fp_retire_i;
    assign flag_acc_o    = fp_flags_i & {FFLAGS_W{fp_retire_i}};   // quiet when idle

endmodule

//--- verilog/csr_wb_buffer.sv
// one-entry writeback holding register; loader must not load while full and not ready
`timescale 1ns/10ps

module csr_wb_buffer import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // load side
    input  logic                   load_i,
    input  logic [REG_ADDR_W-1:0]  waddr_i,
    input  logic [XLEN-1:0]        wdata_i,       // old csr value
    input  logic [COMMIT_ID_W-1:0] commit_id_i,

    // writeback side
    input  logic                   wb_ready_i,
    output logic                   buf_full_o,
    output logic                   wb_valid_o,
    output logic [REG_ADDR_W-1:0]  wb_waddr_o,
    output logic [XLEN-1:0]        wb_wdata_o,
    output logic [COMMIT_ID_W-1:0] wb_commit_id_o
);

    logic                   valid_q;
    logic [REG_ADDR_W-1:0]  waddr_q;
    logic [XLEN-1:0]        wdata_q;
    logic [COMMIT_ID_W-1:0] cid_q;

    // occupancy, load wins so drain and refill can share a cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            valid_q <= 1'b0;    // entry taken
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (load_i) begin
            waddr_q <= waddr_i;
            wdata_q <= wdata_i;
            cid_q   <= commit_id_i;
        end
    end

    assign buf_full_o     = valid_q;
    assign wb_valid_o     = valid_q;   // held until wb_ready_i
    assign wb_waddr_o     = waddr_q;
    assign wb_wdata_o     = wdata_q;
    assign wb_commit_id_o = cid_q;

endmodule

//--- verilog/csr_subsys_top.sv
// csr execution slice; immediate forms, privilege traps, counters and trap entry not handled
`timescale 1ns/10ps

module csr_subsys_top import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // csr request
    input  logic                   req_csr_i,
    input  csr_op_e                csr_op_i,
    input  logic [CSR_ADDR_W-1:0]  csr_addr_i,
    input  logic [XLEN-1:0]        csr_op1_i,
    input  logic                   reg_we_i,
    input  logic [REG_ADDR_W-1:0]  reg_waddr_i,
    input  logic [COMMIT_ID_W-1:0] commit_id_i,
    input  logic                   int_assert_i,
    output logic                   csr_stall_o,

    // fp events
    input  logic                   fp_issue_i,
    input  logic                   fp_retire_i,
    input  logic [FFLAGS_W-1:0]    fp_flags_i,

    // integer writeback
    input  logic                   wb_ready_i,
    output logic                   wb_valid_o,
    output logic [REG_ADDR_W-1:0]  wb_waddr_o,
    output logic [XLEN-1:0]        wb_wdata_o,
    output logic [COMMIT_ID_W-1:0] wb_commit_id_o
);

    logic                csr_we;
    logic                buf_load;
    logic                wen_req;
    logic                buf_full;
    logic                fp_pending;
    logic                flag_acc_en;
    logic [FFLAGS_W-1:0] flag_acc;
    logic [XLEN-1:0]     csr_rdata;   // old value, also the writeback data
    logic [XLEN-1:0]     csr_wdata;

    csr_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_csr_i    (req_csr_i),
        .int_assert_i (int_assert_i),
        .csr_addr_i   (csr_addr_i),
        .reg_we_i     (reg_we_i),
        .wen_req_i    (wen_req),
        .buf_full_i   (buf_full),
        .wb_ready_i   (wb_ready_i),
        .fp_pending_i (fp_pending),
        .accept_o     (),             // folded into the two strobes
        .csr_we_o     (csr_we),
        .buf_load_o   (buf_load),
        .csr_stall_o  (csr_stall_o)
    );

    csr_alu u_alu (
        .csr_op_i    (csr_op_i),
        .csr_op1_i   (csr_op1_i),
        .csr_rdata_i (csr_rdata),
        .csr_wdata_o (csr_wdata),
        .wen_req_o   (wen_req)
    );

    csr_regfile u_regfile (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .raddr_i       (csr_addr_i),
        .we_i          (csr_we),
        .wdata_i       (csr_wdata),
        .flag_acc_en_i (flag_acc_en),
        .flag_acc_i    (flag_acc),
        .rdata_o       (csr_rdata)
    );

    fp_flag_tracker u_fp_track (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fp_issue_i    (fp_issue_i),
        .fp_retire_i   (fp_retire_i),
        .fp_flags_i    (fp_flags_i),
        .fp_pending_o  (fp_pending),
        .flag_acc_en_o (flag_acc_en),
        .flag_acc_o    (flag_acc)
    );

    csr_wb_buffer u_wb_buf (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .load_i         (buf_load),
        .waddr_i        (reg_waddr_i),
        .wdata_i        (csr_rdata),
        .commit_id_i    (commit_id_i),
        .wb_ready_i     (wb_ready_i),
        .buf_full_o     (buf_full),
        .wb_valid_o     (wb_valid_o),
        .wb_waddr_o     (wb_waddr_o),
        .wb_wdata_o     (wb_wdata_o),
        .wb_commit_id_o (wb_commit_id_o)
    );

endmodule

//--- sim/tb_csr_subsys.sv
// run from the project root so sim/csr_vectors.txt is found; the first mismatch or timeout ends the run
`timescale 1ns/10ps

module tb_csr_subsys import csr_pkg::*; ();

    localparam int TIMEOUT     = 60;   // cycles allowed per wait
    localparam int HOLD_CYCLES = 8;    // ready held low for back-pressure

    logic                   clk;
    logic                   rst_n_i;
    logic                   req_csr_i;
    csr_op_e                csr_op_i;
    logic [CSR_ADDR_W-1:0]  csr_addr_i;
    logic [XLEN-1:0]        csr_op1_i;
    logic                   reg_we_i;
    logic [REG_ADDR_W-1:0]  reg_waddr_i;
    logic [COMMIT_ID_W-1:0] commit_id_i;
    logic                   int_assert_i;
    logic                   csr_stall_o;
    logic                   fp_issue_i;
    logic                   fp_retire_i;
    logic [FFLAGS_W-1:0]    fp_flags_i;
    logic                   wb_ready_i;
    logic                   wb_valid_o;
    logic [REG_ADDR_W-1:0]  wb_waddr_o;
    logic [XLEN-1:0]        wb_wdata_o;
    logic [COMMIT_ID_W-1:0] wb_commit_id_o;

    int          hold_cnt;    // set on falling edges, counted down on rising
    logic        rand_mode;
    integer      seed;
    logic [31:0] rnd;
    int          err_cnt;
    int          wait_n;
    string       mon_tag;

    // expected writebacks, request order
    logic [31:0] exp_data_q[$];
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_cid_q[$];
    int          exp_line_q[$];

    // current vector line
    int          fd;
    int          code;
    int          ln;
    string       line;
    logic [7:0]  kind;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_op1;
    logic [31:0] f_we;
    logic [31:0] f_waddr;
    logic [31:0] f_cid;
    logic [31:0] f_int;
    logic [31:0] f_wbr;
    logic [31:0] f_exp;

    csr_subsys_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // writeback ready: held low, random gaps, or high
    always @(posedge clk) begin
        if (hold_cnt > 0) begin
            wb_ready_i <= 1'b0;
            hold_cnt = hold_cnt - 1;
        end else if (rand_mode) begin
            rnd = $random(seed);
            wb_ready_i <= (rnd[1:0] != 2'b00);   // ready about 3 cycles in 4
        end else begin
            wb_ready_i <= 1'b1;
        end
    end

    task automatic abort_run(input string why);
        err_cnt++;
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            err_cnt++;
            $display("** Error %s: expected %h, actual %h", name, exp_v, act_v);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // handshake seen at the falling edge completes on the next rising edge
    always @(negedge clk) begin
        if (rst_n_i && wb_valid_o && wb_ready_i) begin
            if (exp_data_q.size() == 0) begin
                abort_run("writeback result appeared with no request waiting for one");
            end else begin
                mon_tag = $sformatf("line %0d", exp_line_q.pop_front());
                check_val({mon_tag, " wdata"}, exp_data_q.pop_front(), wb_wdata_o);
                check_val({mon_tag, " waddr"}, exp_addr_q.pop_front(), wb_waddr_o);
                check_val({mon_tag, " commit id"}, exp_cid_q.pop_front(), wb_commit_id_o);
            end
        end
    end

    task automatic drive_req;
        @(negedge clk);
        hold_cnt  = (f_wbr == 0) ? HOLD_CYCLES : 0;   // 0 holds ready low a while
        rand_mode = (f_wbr == 2);
        @(posedge clk);
        req_csr_i    <= 1'b1;
        csr_op_i     <= csr_op_e'(f_op[1:0]);
        csr_addr_i   <= f_addr[CSR_ADDR_W-1:0];
        csr_op1_i    <= f_op1;
        reg_we_i     <= f_we[0];
        reg_waddr_i  <= f_waddr[REG_ADDR_W-1:0];
        commit_id_i  <= f_cid[COMMIT_ID_W-1:0];
        int_assert_i <= f_int[0];
        if (f_we[0] && !f_int[0]) begin   // only these reach writeback
            exp_data_q.push_back(f_exp);
            exp_addr_q.push_back(f_waddr);
            exp_cid_q.push_back(f_cid);
            exp_line_q.push_back(ln);
        end
    endtask

    task automatic wait_accept;
        int n;
        n = 0;
        @(negedge clk);
        while (csr_stall_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (csr_stall_o) begin
            abort_run($sformatf("line %0d, csr_stall_o never dropped", ln));
        end else begin
            @(posedge clk);
            req_csr_i <= 1'b0;   // taken on this edge
        end
    endtask

    // f_op issue, f_op1 retire, f_exp flags
    task automatic pulse_fp;
        @(negedge clk);
        if (req_csr_i) begin
            check_val($sformatf("line %0d fp stall", ln), 1, csr_stall_o);
        end
        @(posedge clk);
        fp_issue_i  <= f_op[0];
        fp_retire_i <= f_op1[0];
        fp_flags_i  <= f_exp[FFLAGS_W-1:0];
        @(posedge clk);
        fp_issue_i  <= 1'b0;
        fp_retire_i <= 1'b0;
        fp_flags_i  <= '0;
    endtask

    task automatic run_line;
        int n;
        kind = line.getc(0);
        case (kind)
            "F": begin
                n = $sscanf(line, "%c %h %h %h", kind, f_op, f_op1, f_exp);
                if (n != 4) begin
                    abort_run($sformatf("line %0d of the vector file is malformed", ln));
                end else begin
                    pulse_fp();
                end
            end
            "W": wait_accept();   // request left held by an H line
            "R", "B", "H": begin
                n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h", kind, f_op, f_addr,
                            f_op1, f_we, f_waddr, f_cid, f_int, f_wbr, f_exp);
                if (n != 10) begin
                    abort_run($sformatf("line %0d of the vector file is malformed", ln));
                end else if (f_int[0]) begin
                    drive_req();
                    @(posedge clk);
                    req_csr_i    <= 1'b0;   // dropped, not retried
                    int_assert_i <= 1'b0;
                end else if (kind == "H") begin
                    drive_req();
                    @(negedge clk);
                    check_val($sformatf("line %0d fp stall", ln), 1, csr_stall_o);
                end else begin
                    drive_req();
                    wait_accept();
                end
            end
            default: abort_run($sformatf("line %0d has an unknown vector kind", ln));
        endcase
    endtask

    initial begin
        seed         = 32'h4c04d85a;
        hold_cnt     = 0;
        rand_mode    = 1'b0;
        err_cnt      = 0;
        ln           = 0;
        rst_n_i      = 1'b0;
        req_csr_i    = 1'b0;
        csr_op_i     = OP_NONE;
        csr_addr_i   = '0;
        csr_op1_i    = '0;
        reg_we_i     = 1'b0;
        reg_waddr_i  = '0;
        commit_id_i  = '0;
        int_assert_i = 1'b0;
        fp_issue_i   = 1'b0;
        fp_retire_i  = 1'b0;
        fp_flags_i   = '0;
        wb_ready_i   = 1'b1;
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_val("reset wb_valid", 0, wb_valid_o);
        fd = $fopen("sim/csr_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open sim/csr_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                ln++;
                if (code > 1 && line.getc(0) != 8'h23) begin   // skip blanks and # lines
                    run_line();
                end
            end
            $fclose(fd);
            @(negedge clk);
            hold_cnt  = 0;   // drain with ready high
            rand_mode = 1'b0;
            wait_n    = 0;
            while (exp_data_q.size() != 0 && wait_n < TIMEOUT) begin
                @(negedge clk);
                wait_n++;
            end
            if (exp_data_q.size() != 0) begin
                abort_run("expected writeback results never arrived");
            end else begin
                repeat (4) @(negedge clk);   // a repeated result would show up here
                if (err_cnt == 0) begin
                    $display("test passed");
                    $finish;
                end else begin
                    $display("test failed");
                    $fatal(1, "checks failed");
                end
            end
        end
    end

endmodule

//--- src.f
verilog/csr_pkg.sv
verilog/csr_alu.sv
verilog/csr_ctrl.sv
verilog/csr_regfile.sv
verilog/fp_flag_tracker.sv
verilog/csr_wb_buffer.sv
verilog/csr_subsys_top.sv
sim/tb_csr_subsys.sv

//--- sim/csr_vectors.txt
# kind op addr op1 reg_we waddr cid int wb_ready expect, hex; op 1 rw 2 rs 3 rc
# R req B readback H fp-held W wait F issue retire flags; wb_ready 0 low 8, 1 high, 2 random
R 1 340 a5a5f00f 1 01 0 0 1 00000000
R 2 340 0000ff00 1 02 1 0 1 a5a5f00f
R 3 340 a0000005 1 03 2 0 1 a5a5ff0f
B 2 340 00000000 1 04 3 0 1 05a5ff0a
R 1 305 12345677 1 05 4 0 1 00000000
B 2 305 00000000 1 06 5 0 1 12345674
R 1 341 8000000b 1 07 6 0 1 00000000
B 2 341 00000000 1 08 7 0 1 80000008
R 1 002 000000ff 1 09 8 0 1 00000000
B 2 002 00000000 1 0a 9 0 1 00000007
R 1 003 000000e5 1 0b a 0 1 000000e0
B 2 001 00000000 1 0c b 0 1 00000005
B 2 002 00000000 1 0d c 0 1 00000007
B 2 003 00000000 1 0e d 0 1 000000e5
R 1 300 00001888 0 0f e 0 1 00000000
B 2 300 00000000 1 0f f 0 1 00001888
R 1 7c0 deadbeef 1 10 0 0 1 00000000
B 2 7c0 00000000 1 11 1 0 1 00000000
R 2 305 00000000 1 12 2 0 1 12345674
R 3 305 00000000 1 13 3 0 1 12345674
R 1 340 11111111 1 14 4 1 1 00000000
B 2 340 00000000 1 15 5 0 1 05a5ff0a
R 1 001 00000000 1 16 6 0 1 00000005
F 1 0 00
F 1 0 00
H 2 001 00000000 1 17 7 0 1 00000013
F 0 1 01
F 0 1 12
W
F 1 1 08
B 2 003 00000000 1 18 8 0 1 000000fb
R 1 340 00000001 1 19 9 0 0 05a5ff0a
R 1 340 00000002 1 1a a 0 0 00000001
R 1 340 00000003 1 1b b 0 0 00000002
R 2 340 00000010 0 1c c 0 0 00000000
R 1 340 00000020 1 1d d 0 1 00000013
R 1 340 00000021 1 1e e 0 2 00000020
R 3 340 00000001 1 1f f 0 2 00000021
R 2 340 00000104 1 01 0 0 2 00000020
R 1 340 cafe0000 1 02 1 0 2 00000124
R 1 341 00000103 1 03 2 0 2 80000008
B 2 341 00000000 1 04 3 0 2 00000100
B 2 340 00000000 1 05 4 0 1 cafe0000
